// File: hdl/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    localparam int RS_DEPTH   = 8;  // Default station size.
    localparam int MUL_CYCLES = 8;  // Default multiply latency in cycles.

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SLT = 4'd6,
        MUL = 4'd7
    } alu_op_t;

    typedef logic [3:0]  rs_tag_t;   // Zero means the value is present.
    typedef logic [2:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        logic     use_imm;  // Operand two comes from imm.
        word_t    imm;
    } issue_t;

    typedef struct packed {
        rs_tag_t tag;
        word_t   value;
    } operand_t;

    typedef struct packed {
        logic    valid;
        rs_tag_t tag;
        alu_op_t op;
        word_t   val1;
        word_t   val2;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rs_tag_t tag;
        word_t   value;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    value;
    } writeback_t;

endpackage

`default_nettype wire

// File: hdl/register_status.sv
`timescale 1ns/1ps
`default_nettype none

module register_status import tomasulo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_t     issue,
    input  rs_tag_t    alloc_tag,
    input  cdb_t       cdb,
    output operand_t   opnd1,
    output operand_t   opnd2,
    output writeback_t writeback
);

    localparam int num_regs = 8;

    word_t               reg_val [num_regs];
    rs_tag_t             reg_tag [num_regs];  // Producer of the pending value.
    logic                rename;
    logic [num_regs-1:0] wb_hit;

    // Source read, with the result on the CDB forwarded in the same cycle.
    function automatic operand_t read_reg(input rs_tag_t tag, input word_t value,
                                          input cdb_t bus);
        operand_t opnd;
        opnd.tag   = tag;
        opnd.value = value;
        if (tag != '0 && bus.valid && bus.tag == tag) begin
            opnd.tag   = '0;
            opnd.value = bus.value;
        end
        return opnd;
    endfunction

    // No free entry means alloc_tag is zero and the issue is dropped.
    assign rename = issue_valid && (alloc_tag != '0);

    assign opnd1 = read_reg(reg_tag[issue.src1], reg_val[issue.src1], cdb);
    assign opnd2 = read_reg(reg_tag[issue.src2], reg_val[issue.src2], cdb);

    always_comb begin
        writeback = '0;
        for (int r = 0; r < num_regs; r++) begin
            // A rename in this cycle hides the older producer's result.
            wb_hit[r] = cdb.valid && (reg_tag[r] != '0) && (reg_tag[r] == cdb.tag)
                        && !(rename && issue.dest == reg_idx_t'(r));
            if (wb_hit[r]) begin
                writeback.valid = 1'b1;
                writeback.dest  = reg_idx_t'(r);
                writeback.value = cdb.value;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < num_regs; r++) begin
                reg_val[r] <= '0;
                reg_tag[r] <= '0;
            end
        end else begin
            for (int r = 0; r < num_regs; r++) begin
                if (rename && issue.dest == reg_idx_t'(r)) begin
                    reg_tag[r] <= alloc_tag;  // Newest producer wins.
                end else if (wb_hit[r]) begin
                    reg_tag[r] <= '0;
                    reg_val[r] <= cdb.value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import tomasulo_pkg::*; #(
    parameter int rs_depth = RS_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  issue_t    issue,
    input  operand_t  opnd1,
    input  operand_t  opnd2,
    output rs_tag_t   alloc_tag,
    output logic      full,
    input  cdb_t      cdb,
    input  logic      alu_ready,
    output dispatch_t dispatch
);

    logic [rs_depth-1:0] busy;
    logic [rs_depth-1:0] busy_next;
    logic [rs_depth-1:0] held_mask;
    logic [rs_depth-1:0] held_mask_next;
    logic [rs_depth-1:0] load;
    logic [rs_depth-1:0] cap1;
    logic [rs_depth-1:0] cap2;
    rs_tag_t             held_tag;
    rs_tag_t             held_tag_next;
    rs_tag_t             tag1 [rs_depth];
    rs_tag_t             tag2 [rs_depth];
    alu_op_t             op   [rs_depth];
    word_t               val1 [rs_depth];
    word_t               val2 [rs_depth];
    logic                issue_ok;
    operand_t            src2;

    assign src2 = issue.use_imm ? operand_t'{tag: '0, value: issue.imm} : opnd2;

    assign issue_ok = issue_valid && (alloc_tag != '0);

    // A multiply's entry stays reserved until its broadcast,
    // so its tag is not reused while the result is still in flight.
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            held_mask[i]      = (held_tag == rs_tag_t'(i + 1));
            held_mask_next[i] = (held_tag_next == rs_tag_t'(i + 1));
        end
    end

    always_comb begin
        alloc_tag = '0;  // Lowest free entry.
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!busy[i] && !held_mask[i]) begin
                alloc_tag = rs_tag_t'(i + 1);
            end
        end
    end

    // Lowest ready entry goes to the ALU.
    always_comb begin
        dispatch = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (busy[i] && tag1[i] == '0 && tag2[i] == '0) begin
                dispatch.valid = alu_ready;
                dispatch.tag   = rs_tag_t'(i + 1);
                dispatch.op    = op[i];
                dispatch.val1  = val1[i];
                dispatch.val2  = val2[i];
            end
        end
    end

    always_comb begin
        busy_next     = busy;
        held_tag_next = held_tag;
        if (cdb.valid && cdb.tag == held_tag) begin
            held_tag_next = '0;
        end
        if (dispatch.valid && dispatch.op == MUL) begin
            held_tag_next = dispatch.tag;
        end
        for (int i = 0; i < rs_depth; i++) begin
            load[i] = issue_ok && (alloc_tag == rs_tag_t'(i + 1));
            cap1[i] = busy[i] && cdb.valid && (tag1[i] != '0) && (tag1[i] == cdb.tag);
            cap2[i] = busy[i] && cdb.valid && (tag2[i] != '0) && (tag2[i] == cdb.tag);
            if (dispatch.valid && dispatch.tag == rs_tag_t'(i + 1)) begin
                busy_next[i] = 1'b0;  // Freed on the dispatch edge.
            end
            if (load[i]) begin
                busy_next[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= '0;
            held_tag <= '0;
            full     <= 1'b0;
            for (int i = 0; i < rs_depth; i++) begin
                tag1[i] <= '0;
                tag2[i] <= '0;
            end
        end else begin
            busy     <= busy_next;
            held_tag <= held_tag_next;
            full     <= &(busy_next | held_mask_next);
            for (int i = 0; i < rs_depth; i++) begin
                if (load[i]) begin
                    tag1[i] <= opnd1.tag;
                    tag2[i] <= src2.tag;
                end else begin
                    if (cap1[i]) tag1[i] <= '0;
                    if (cap2[i]) tag2[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (load[i]) begin
                op[i]   <= issue.op;
                val1[i] <= opnd1.value;
                val2[i] <= src2.value;
            end else begin
                if (cap1[i]) val1[i] <= cdb.value;  // Operand wakeup.
                if (cap2[i]) val2[i] <= cdb.value;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import tomasulo_pkg::*; #(
    parameter int mul_cycles = MUL_CYCLES
) (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t dispatch,
    output logic      alu_ready,
    output cdb_t      cdb
);

    localparam int step_bits = (32 + mul_cycles - 1) / mul_cycles;  // Multiplier bits per step.
    localparam int cnt_w     = $clog2(mul_cycles + 1);

    logic [cnt_w-1:0] mul_cnt;  // Steps left, zero when idle.
    word_t            mcand;
    word_t            mplier;
    word_t            acc;
    word_t            step_acc;
    word_t            step_cand;
    word_t            step_plier;
    logic             res_valid;
    rs_tag_t          res_tag;
    word_t            res_value;

    function automatic word_t alu_result(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            default: return '0;
        endcase
    endfunction

    // One multiply step of shift and add over step_bits multiplier bits.
    always_comb begin
        step_acc   = acc;
        step_cand  = mcand;
        step_plier = mplier;
        for (int b = 0; b < step_bits; b++) begin
            if (step_plier[0]) step_acc = step_acc + step_cand;
            step_cand  = step_cand << 1;
            step_plier = step_plier >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mul_cnt   <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (mul_cnt != '0) begin
                mul_cnt   <= mul_cnt - 1'b1;
                res_valid <= (mul_cnt == cnt_w'(1));  // Last step broadcasts.
            end else if (dispatch.valid) begin
                if (dispatch.op == MUL) begin
                    mul_cnt <= cnt_w'(mul_cycles);
                end else begin
                    res_valid <= 1'b1;
                end
            end
        end
    end

    // The tag taken at dispatch stays in res_tag while the multiply runs.
    always_ff @(posedge clk) begin
        if (mul_cnt != '0) begin
            acc       <= step_acc;
            mcand     <= step_cand;
            mplier    <= step_plier;
            res_value <= step_acc;
        end else if (dispatch.valid) begin
            acc       <= '0;
            mcand     <= dispatch.val1;
            mplier    <= dispatch.val2;
            res_tag   <= dispatch.tag;
            res_value <= alu_result(dispatch.op, dispatch.val1, dispatch.val2);
        end
    end

    assign alu_ready = (mul_cnt == '0);
    assign cdb       = cdb_t'{valid: res_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

// File: hdl/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core import tomasulo_pkg::*; #(
    parameter int rs_depth   = RS_DEPTH,
    parameter int mul_cycles = MUL_CYCLES
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       full,
    output cdb_t       cdb,
    output writeback_t writeback
);

    operand_t  opnd1;
    operand_t  opnd2;
    rs_tag_t   alloc_tag;  // Entry taken by the current issue.
    dispatch_t dispatch;
    logic      alu_ready;

    register_status u_register_status (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alloc_tag   (alloc_tag),
        .cdb         (cdb),
        .opnd1       (opnd1),
        .opnd2       (opnd2),
        .writeback   (writeback)
    );

    reservation_station #(
        .rs_depth (rs_depth)
    ) u_reservation_station (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .opnd1       (opnd1),
        .opnd2       (opnd2),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .cdb         (cdb),
        .alu_ready   (alu_ready),
        .dispatch    (dispatch)
    );

    // Single execution unit, sole driver of the CDB.
    alu_unit #(
        .mul_cycles (mul_cycles)
    ) u_alu_unit (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (dispatch),
        .alu_ready (alu_ready),
        .cdb       (cdb)
    );

endmodule

`default_nettype wire

// File: bench/tomasulo_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core_props import tomasulo_pkg::*; #(
    parameter int rs_depth = RS_DEPTH
) (
    input logic                clk,
    input logic                rst,
    input logic [rs_depth-1:0] busy,
    input logic                full,
    input logic                alu_ready,
    input dispatch_t           dispatch
);

    // No free entry left to offer.
    full_when_busy: assert property (@(posedge clk) disable iff (rst) &busy |-> full)
        else $error("full is low while every entry is busy");

    ready_on_dispatch: assert property (@(posedge clk) disable iff (rst)
        dispatch.valid |-> alu_ready)
        else $error("dispatch while the ALU is busy");

    tag_nonzero: assert property (@(posedge clk) disable iff (rst)
        dispatch.valid |-> dispatch.tag != '0)  // Zero is the ready tag.
        else $error("dispatch carries tag zero");

endmodule

bind reservation_station tomasulo_core_props #(
    .rs_depth (rs_depth)
) props_i (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .full      (full),
    .alu_ready (alu_ready),
    .dispatch  (dispatch)
);

`default_nettype wire

// File: bench/tomasulo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core_tb import tomasulo_pkg::*; ();

    localparam int rs_depth   = RS_DEPTH;
    localparam int mul_cycles = MUL_CYCLES;
    localparam int wait_limit = 2000;  // Cycles allowed per wait.

    logic       clk = 1'b0;
    logic       rst;
    logic       issue_valid;
    issue_t     issue;
    logic       full;
    cdb_t       cdb;
    writeback_t writeback;

    word_t  shadow    [8] = '{default: '0};  // Registers after in-order execution.
    int     issues_to [8] = '{default: 0};
    int     wb_seen   [8] = '{default: 0};   // Value of issues_to at the last writeback.
    word_t  pending   [$];                   // Results still owed on the CDB.
    integer seed;
    int     issued      = 0;
    int     broadcasts  = 0;
    int     full_cycles = 0;
    int     checks      = 0;
    int     errors      = 0;
    int     wb_checks   = 0;
    int     wb_errors   = 0;
    int     tests       = 0;
    int     err_mark    = 0;
    logic   timed_out   = 1'b0;

    tomasulo_core #(
        .rs_depth   (rs_depth),
        .mul_cycles (mul_cycles)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (full),
        .cdb         (cdb),
        .writeback   (writeback)
    );

    always #2 clk = ~clk;

    function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
        word_t r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a + ~b + 32'd1;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLL:     r = a << b[4:0];
            SLT:     r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};  // Signed.
            MUL:     r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic issue_t make_instr(input alu_op_t op, input int dest, input int src1,
                                          input int src2, input logic use_imm, input word_t imm);
        issue_t ins;
        ins.op      = op;
        ins.dest    = reg_idx_t'(dest);
        ins.src1    = reg_idx_t'(src1);
        ins.src2    = reg_idx_t'(src2);
        ins.use_imm = use_imm;
        ins.imm     = imm;
        return ins;
    endfunction

    // Only the newest producer of a register may write it back.
    task automatic check_writeback(input writeback_t wb);
        wb_checks++;
        if (wb_seen[wb.dest] == issues_to[wb.dest]) begin
            wb_errors++;
            $display("Writeback to r%0d with no instruction outstanding", wb.dest);
        end else if (wb.value !== shadow[wb.dest]) begin
            wb_errors++;
            $display("[FAIL] writeback.value r%0d got %h expected %h",
                     wb.dest, wb.value, shadow[wb.dest]);
        end
        wb_seen[wb.dest] = issues_to[wb.dest];
    endtask

    // Each broadcast carries the result of one instruction still in flight.
    task automatic check_cdb(input cdb_t bus);
        int hit;
        hit = -1;
        wb_checks++;
        if (bus.tag == '0 || bus.tag > rs_depth) begin
            wb_errors++;
            $display("CDB broadcast carries tag %0d, which names no station entry", bus.tag);
        end
        foreach (pending[i]) begin
            if (hit < 0 && pending[i] === bus.value) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            wb_errors++;
            $display("[FAIL] cdb.value got %h, matching no outstanding result", bus.value);
        end else begin
            pending.delete(hit);
        end
    endtask

    task automatic check_reg(input reg_idx_t idx, input word_t got);
        checks++;
        if (got !== shadow[idx]) begin
            errors++;
            $display("[FAIL] reg_val[%0d] got %h expected %h", idx, got, shadow[idx]);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (cdb.valid) begin
                broadcasts++;
                check_cdb(cdb);
            end
            if (full) full_cycles++;
            if (writeback.valid) check_writeback(writeback);
        end
    end

    task automatic issue_instr(input issue_t ins);
        int    waited;
        word_t b;
        waited = 0;
        if (!timed_out) begin
            while (full && waited < wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (full) begin
                timed_out = 1'b1;
                $display("Timed out waiting for full to fall before an issue");
            end else begin
                b = ins.use_imm ? ins.imm : shadow[ins.src2];
                shadow[ins.dest] = ref_alu(ins.op, shadow[ins.src1], b);
                pending.push_back(shadow[ins.dest]);
                issues_to[ins.dest]++;
                issued++;
                issue_valid = 1'b1;
                issue       = ins;
                @(negedge clk);
                issue_valid = 1'b0;
            end
        end
    endtask

    // Every issued instruction broadcasts once, masked or not.
    task automatic drain();
        int waited;
        waited = 0;
        if (!timed_out) begin
            while (broadcasts < issued && waited < wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (broadcasts < issued) begin
                timed_out = 1'b1;
                $display("Timed out waiting for %0d results on the CDB", issued - broadcasts);
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        drain();
        if (!timed_out) begin
            for (int r = 0; r < 8; r++) begin
                if (wb_seen[r] != issues_to[r]) begin
                    errors++;
                    $display("Register r%0d never received its last writeback", r);
                end
                check_reg(reg_idx_t'(r), dut_i.u_register_status.reg_val[r]);
            end
        end
        tests++;
        errs = errors + wb_errors - err_mark;
        $display("Test %0d %s finished with %0d error(s)", tests, name, errs);
        err_mark = errors + wb_errors;
    endtask

    initial begin
        int         mark;
        int         prev;
        int         dest;
        word_t      rnd;
        word_t      imm;
        logic [3:0] code;
        seed        = 49;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Immediate ops fanning out from r1.
        issue_instr(make_instr(ADD, 1, 0, 0, 1'b1, 32'h8765_4321));
        issue_instr(make_instr(SUB, 2, 1, 0, 1'b1, 32'h0000_1111));
        issue_instr(make_instr(AND, 3, 1, 0, 1'b1, 32'h00ff_ff00));
        issue_instr(make_instr(OR,  4, 1, 0, 1'b1, 32'h0000_000f));
        issue_instr(make_instr(XOR, 5, 1, 0, 1'b1, 32'hffff_ffff));
        issue_instr(make_instr(SLL, 6, 1, 0, 1'b1, 32'h0000_0024));  // Shift by 4.
        issue_instr(make_instr(SLT, 7, 1, 0, 1'b1, 32'h0000_0005));
        finish_test("immediate operations");

        prev = 2;
        for (int k = 0; k < 16; k++) begin
            code = 4'(k % 8);
            dest = (k * 3 + 1) % 8;
            issue_instr(make_instr(alu_op_t'(code), dest, prev, (k + 5) % 8, 1'b0, '0));
            prev = dest;
        end
        finish_test("dependency chains");

        // MUL holds the ALU while the station fills behind it.
        mark = full_cycles;
        issue_instr(make_instr(MUL, 0, 1, 0, 1'b1, 32'h0001_0003));
        for (int k = 0; k < 9; k++) begin
            issue_instr(make_instr(ADD, 2 + k % 6, 1, 0, 1'b1, word_t'(k * 17)));
        end
        drain();
        checks++;
        if (!timed_out && full_cycles == mark) begin
            errors++;
            $display("full never rose while the multiply held the ALU");
        end
        finish_test("multiply stall and full");

        issue_instr(make_instr(MUL, 5, 2, 0, 1'b1, 32'h0000_1357));
        issue_instr(make_instr(ADD, 5, 3, 0, 1'b1, 32'h0000_0042));
        finish_test("write-after-write");

        for (int n = 0; n < 200; n++) begin
            rnd  = $random(seed);
            imm  = $random(seed);
            code = {1'b0, rnd[2:0]};
            issue_instr(make_instr(alu_op_t'(code), int'(rnd[6:4]), int'(rnd[10:8]),
                                   int'(rnd[14:12]), rnd[16], imm));
        end
        finish_test("random stream");

        $display("Tests %0d, checks %0d, errors %0d%s", tests, checks + wb_checks,
                 errors + wb_errors, timed_out ? ", stopped by a timeout" : "");
        if (errors + wb_errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/tomasulo_pkg.sv
hdl/register_status.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/tomasulo_core.sv
bench/tomasulo_core_props.sv
bench/tomasulo_core_tb.sv

// File: Makefile
# Verilator build and run for the Tomasulo core testbench.

VERILATOR ?= verilator
TOP       ?= tomasulo_core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "No result found in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
